/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Major opcodes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } rv_opcode_e;

  // OP and OP-IMM funct3
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_alt = 7'b0100000;  // Selects sub and sra

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction formats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } rv_instr_t;

endpackage

/* design/exec_ctrl_pkg.sv */
package exec_ctrl_pkg;

  // Compare operations put their outcome in bit 0
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {
    npc_seq,     // pc + 4
    npc_jal,     // pc + imm
    npc_jalr,    // ALU result with bit 0 cleared
    npc_branch   // pc + imm when ALU bit 0 is set
  } npc_sel_e;

  typedef enum logic [1:0] {
    wdata_alu,
    wdata_snpc,  // Link address of jal and jalr
    wdata_dnpc   // auipc
  } wdata_sel_e;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_exe,
    fwd_imm
  } fwd_sel_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] src1;
    logic [31:0] src2;
    fwd_sel_e    op1_sel;
    fwd_sel_e    op2_sel;
    alu_op_e     alu_op;
    npc_sel_e    npc_sel;
    wdata_sel_e  wdata_sel;
    logic [4:0]  rd;
    logic        rd_we;
  } dec_ctrl_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] data;
  } commit_t;

endpackage

/* design/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  exec_ctrl_pkg::alu_op_e alu_op,
  input  logic [31:0]            operand1,
  input  logic [31:0]            operand2,
  output logic [31:0]            result
);
  import exec_ctrl_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = operand2[4:0];
  assign lt_s  = $signed(operand1) < $signed(operand2);
  assign lt_u  = operand1 < operand2;

  always_comb begin
    case (alu_op)
      alu_add:  result = operand1 + operand2;
      alu_sub:  result = operand1 - operand2;
      alu_sll:  result = operand1 << shamt;
      alu_slt:  result = {31'b0, lt_s};
      alu_sltu: result = {31'b0, lt_u};
      alu_xor:  result = operand1 ^ operand2;
      alu_srl:  result = operand1 >> shamt;
      alu_sra:  result = $unsigned($signed(operand1) >>> shamt);
      alu_or:   result = operand1 | operand2;
      alu_and:  result = operand1 & operand2;
      // Branch compares
      alu_eq:   result = {31'b0, operand1 == operand2};
      alu_ne:   result = {31'b0, operand1 != operand2};
      alu_lt:   result = {31'b0, lt_s};
      alu_ge:   result = {31'b0, !lt_s};
      alu_ltu:  result = {31'b0, lt_u};
      alu_geu:  result = {31'b0, !lt_u};
      default:  result = '0;
    endcase
  end

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder #(
  parameter int num_regs = 32
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      block,
  input  logic                      instr_valid,
  input  rv_isa_pkg::rv_instr_t     instr,
  input  logic [31:0]               pc,
  input  logic                      clear_pipeline,
  input  logic [31:0]               rs1_data,
  input  logic [31:0]               rs2_data,
  output logic [4:0]                rs1_addr,
  output logic [4:0]                rs2_addr,
  output exec_ctrl_pkg::dec_ctrl_t  dec
);
  import rv_isa_pkg::*;
  import exec_ctrl_pkg::*;

  dec_ctrl_t   dec_d;
  logic        legal;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        writes_rd;
  logic        imm_op2;
  logic [4:0]  rd_idx;
  logic [31:0] imm;
  alu_op_e     alu_op;
  npc_sel_e    npc_sel;
  wdata_sel_e  wdata_sel;

  // RV32E folds x16..x31 onto x0
  function automatic logic [4:0] map_reg(input logic [4:0] idx);
    map_reg = (32'(idx) < num_regs) ? idx : 5'd0;
  endfunction

  function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
      f3_add_sub: arith_op = alt ? alu_sub : alu_add;
      f3_sll:     arith_op = alu_sll;
      f3_slt:     arith_op = alu_slt;
      f3_sltu:    arith_op = alu_sltu;
      f3_xor:     arith_op = alu_xor;
      f3_srl_sra: arith_op = alt ? alu_sra : alu_srl;
      f3_or:      arith_op = alu_or;
      f3_and:     arith_op = alu_and;
      default:    arith_op = alu_add;
    endcase
  endfunction

  always_comb begin
    legal     = 1'b1;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes_rd = 1'b1;
    imm_op2   = 1'b0;
    imm       = '0;
    alu_op    = alu_add;
    npc_sel   = npc_seq;
    wdata_sel = wdata_alu;
    case (instr.r_fmt.opcode)
      op_lui: begin
        imm     = {instr.u_fmt.imm_31_12, 12'b0};
        imm_op2 = 1'b1;  // x0 plus the immediate
      end
      op_auipc: begin
        imm       = {instr.u_fmt.imm_31_12, 12'b0};
        wdata_sel = wdata_dnpc;
      end
      op_jal: begin
        imm       = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                     instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
        npc_sel   = npc_jal;
        wdata_sel = wdata_snpc;
      end
      op_jalr: begin
        uses_rs1  = 1'b1;
        imm       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        imm_op2   = 1'b1;
        npc_sel   = npc_jalr;
        wdata_sel = wdata_snpc;
      end
      op_branch: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b0;
        imm       = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                     instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
        npc_sel   = npc_branch;
        case (instr.b_fmt.funct3)
          f3_beq:  alu_op = alu_eq;
          f3_bne:  alu_op = alu_ne;
          f3_blt:  alu_op = alu_lt;
          f3_bge:  alu_op = alu_ge;
          f3_bltu: alu_op = alu_ltu;
          f3_bgeu: alu_op = alu_geu;
          default: legal = 1'b0;
        endcase
      end
      op_imm: begin
        uses_rs1 = 1'b1;
        imm      = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        imm_op2  = 1'b1;
        alu_op   = arith_op(instr.i_fmt.funct3, (instr.i_fmt.funct3 == f3_srl_sra) &&
                            (instr.i_fmt.imm[11:5] == f7_alt));
      end
      op_reg: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        alu_op   = arith_op(instr.r_fmt.funct3, instr.r_fmt.funct7 == f7_alt);
      end
      default: begin
        legal     = 1'b0;
        writes_rd = 1'b0;
      end
    endcase
  end

  // Register fields sit at the same bits in every view that has them
  assign rs1_addr = uses_rs1 ? map_reg(instr.r_fmt.rs1) : 5'd0;
  assign rs2_addr = uses_rs2 ? map_reg(instr.r_fmt.rs2) : 5'd0;
  assign rd_idx   = map_reg(instr.r_fmt.rd);

  always_comb begin
    dec_d.valid     = instr_valid && legal && !clear_pipeline;
    dec_d.pc        = pc;
    dec_d.imm       = imm;
    dec_d.src1      = rs1_data;
    dec_d.src2      = rs2_data;
    dec_d.alu_op    = alu_op;
    dec_d.npc_sel   = npc_sel;
    dec_d.wdata_sel = wdata_sel;
    dec_d.rd        = rd_idx;
    dec_d.rd_we     = writes_rd && (rd_idx != 5'd0);
    // A match on the last registered instruction takes its result from execute
    dec_d.op1_sel   = (dec.valid && dec.rd_we && dec.rd == rs1_addr) ? fwd_exe : fwd_reg;
    if (imm_op2) begin
      dec_d.op2_sel = fwd_imm;
    end else if (dec.valid && dec.rd_we && dec.rd == rs2_addr) begin
      dec_d.op2_sel = fwd_exe;
    end else begin
      dec_d.op2_sel = fwd_reg;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dec.valid <= 1'b0;
    end else if (!block) begin
      dec <= dec_d;
    end
  end

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      block,
  input  exec_ctrl_pkg::dec_ctrl_t  dec,
  output exec_ctrl_pkg::commit_t    commit,
  output logic [31:0]               npc,
  output logic                      clear_pipeline
);
  import exec_ctrl_pkg::*;

  logic        valid_q;
  alu_op_e     alu_op_q;
  logic [31:0] operand1_q;
  logic [31:0] operand2_q;
  logic [31:0] snpc_q;
  logic [31:0] dnpc_q;
  npc_sel_e    npc_sel_q;
  wdata_sel_e  wdata_sel_q;
  logic [4:0]  rd_q;
  logic        rd_we_q;

  logic [31:0] operand1_d;
  logic [31:0] operand2_d;
  logic [31:0] alu_result;
  logic [31:0] exe_wdata;
  logic        taken;

  rv_alu rv_alu_inst (
    .alu_op   (alu_op_q),
    .operand1 (operand1_q),
    .operand2 (operand2_q),
    .result   (alu_result)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand selection and buffering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign operand1_d = (dec.op1_sel == fwd_exe) ? exe_wdata : dec.src1;

  always_comb begin
    case (dec.op2_sel)
      fwd_exe: operand2_d = exe_wdata;  // Result of the instruction leaving now
      fwd_imm: operand2_d = dec.imm;
      default: operand2_d = dec.src2;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (!block) begin
      valid_q <= dec.valid && !clear_pipeline;  // Squash the wrong-path entry
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      alu_op_q    <= dec.alu_op;
      operand1_q  <= operand1_d;
      operand2_q  <= operand2_d;
      snpc_q      <= dec.pc + 32'd4;
      dnpc_q      <= dec.pc + dec.imm;
      npc_sel_q   <= dec.npc_sel;
      wdata_sel_q <= dec.wdata_sel;
      rd_q        <= dec.rd;
      rd_we_q     <= dec.rd_we;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next PC and write data
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (npc_sel_q)
      npc_jal:    npc = dnpc_q;
      npc_jalr:   npc = alu_result & ~32'd1;
      npc_branch: npc = alu_result[0] ? dnpc_q : snpc_q;
      default:    npc = snpc_q;
    endcase
  end

  always_comb begin
    case (wdata_sel_q)
      wdata_snpc: exe_wdata = snpc_q;
      wdata_dnpc: exe_wdata = dnpc_q;
      default:    exe_wdata = alu_result;
    endcase
  end

  // A branch that falls through keeps the sequential stream
  assign taken = (npc_sel_q == npc_jal) || (npc_sel_q == npc_jalr) ||
                 ((npc_sel_q == npc_branch) && alu_result[0]);

  assign commit.valid   = valid_q && !block;
  assign commit.rd      = rd_q;
  assign commit.we      = rd_we_q;
  assign commit.data    = exe_wdata;
  assign clear_pipeline = commit.valid && taken;

endmodule

/* design/rv_commit.sv */
`timescale 1ns/1ps

module rv_commit #(
  parameter int num_regs = 32
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    block,
  input  exec_ctrl_pkg::commit_t  commit,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  output logic [31:0]             rs1_data,
  output logic [31:0]             rs2_data
);
  import exec_ctrl_pkg::*;

  localparam int addr_w = $clog2(num_regs);

  logic [31:0] regs [num_regs];
  logic        wr_en;

  assign wr_en = commit.valid && commit.we && !block;

  // Same-cycle write is passed straight to the reader
  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      read_port = '0;
    end else if (wr_en && commit.rd == addr) begin
      read_port = commit.data;
    end else begin
      read_port = regs[addr[addr_w-1:0]];
    end
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[commit.rd[addr_w-1:0]] <= commit.data;  // Decoder never sends rd past num_regs
    end
  end

endmodule

/* design/rv_exec_core.sv */
`timescale 1ns/1ps

module rv_exec_core #(
  parameter int num_regs = 32
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    block,
  input  logic                    instr_valid,
  input  rv_isa_pkg::rv_instr_t   instr,
  input  logic [31:0]             pc,
  output exec_ctrl_pkg::commit_t  commit,
  output logic                    redirect_valid,
  output logic [31:0]             redirect_pc
);
  import exec_ctrl_pkg::*;

  dec_ctrl_t   dec;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        clear_pipeline;

  rv_decoder #(
    .num_regs (num_regs)
  ) rv_decoder_inst (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .pc             (pc),
    .clear_pipeline (clear_pipeline),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .dec            (dec)
  );

  rv_execute rv_execute_inst (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .dec            (dec),
    .commit         (commit),
    .npc            (redirect_pc),
    .clear_pipeline (clear_pipeline)
  );

  rv_commit #(
    .num_regs (num_regs)
  ) rv_commit_inst (
    .clock    (clock),
    .reset    (reset),
    .block    (block),
    .commit   (commit),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign redirect_valid = clear_pipeline;

endmodule

/* verification/rv_exec_core_checker.sv */
`timescale 1ns/1ps

module rv_exec_core_checker (
  input logic                   clock,
  input logic                   reset,
  input logic                   block,
  input exec_ctrl_pkg::commit_t commit,
  input logic                   redirect_valid
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output rules of the core
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  stall_hides_outputs: assert property (@(posedge clock) disable iff (reset)
    block |-> !commit.valid && !redirect_valid)
    else $error("commit or redirect raised while block is high");

  redirect_needs_commit: assert property (@(posedge clock) disable iff (reset)
    redirect_valid |-> commit.valid)
    else $error("redirect_valid without commit.valid");

  // Writes to x0 are dropped before they reach the register file
  x0_never_written: assert property (@(posedge clock) disable iff (reset)
    commit.valid && commit.rd == 5'd0 |-> !commit.we)
    else $error("commit to x0 with we set");

  idle_after_reset: assert property (@(posedge clock)
    reset |=> !commit.valid && !redirect_valid)
    else $error("valid output high in the cycle after reset");

endmodule

bind rv_exec_core rv_exec_core_checker rv_exec_core_checker_inst (
  .clock          (clock),
  .reset          (reset),
  .block          (block),
  .commit         (commit),
  .redirect_valid (redirect_valid)
);

/* verification/rv_exec_core_tb.sv */
`timescale 1ns/1ps

module rv_exec_core_tb;
  import rv_isa_pkg::*;
  import exec_ctrl_pkg::*;

  localparam int num_slots   = 400;
  localparam int watchdog_ns = num_slots * 2 * 10 + 1000;

  logic        clock;
  logic        reset;
  logic        block;
  logic        instr_valid;
  rv_instr_t   instr;
  logic [31:0] pc;
  commit_t     commit;
  logic        redirect_valid;
  logic [31:0] redirect_pc;

  logic [31:0] regs_model [32];
  commit_t     exp_commit_q[$];
  logic [32:0] exp_redirect_q[$];
  int          errors;
  int          checked;
  int unsigned seed;

  rv_exec_core #(
    .num_regs (32)
  ) rv_exec_core_inst (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .pc             (pc),
    .commit         (commit),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [4:0] pick_reg();
    if ($urandom % 4 == 0) begin
      pick_reg = 5'($urandom % 32);
    end else begin
      pick_reg = 5'($urandom % 8);  // Small set raises the dependency rate
    end
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0: alu_ref = alt ? a - b : a + b;
      3'd1: alu_ref = a << sh;
      3'd2: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: alu_ref = (a < b) ? 32'd1 : 32'd0;
      3'd4: alu_ref = a ^ b;
      3'd5: alu_ref = (a >> sh) | ({32{a[31] & alt}} & ~(32'hffff_ffff >> sh));
      3'd6: alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: branch_ref = (a == b);
      3'd1: branch_ref = (a != b);
      3'd4: branch_ref = $signed(a) < $signed(b);
      3'd5: branch_ref = !($signed(a) < $signed(b));
      3'd6: branch_ref = a < b;
      default: branch_ref = !(a < b);
    endcase
  endfunction

  // Builds one random instruction and, on the correct path, retires it in the model
  task automatic gen_slot(input logic on_path, input logic [31:0] slot_pc,
                          output logic [31:0] word, output logic taken,
                          output logic [31:0] target);
    int          kind;
    int          bsel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic        we;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [20:0] joff;
    logic [12:0] boff;
    logic [31:0] res;
    commit_t     expected;
    kind   = $urandom % 20;
    rd     = pick_reg();
    rs1    = pick_reg();
    rs2    = ($urandom % 4 == 0) ? rs1 : pick_reg();
    f3     = 3'($urandom);
    alt    = 1'($urandom);
    imm12  = 12'($urandom);
    imm20  = 20'($urandom);
    joff   = 21'(($urandom % 1024) * 4) - 21'd2048;
    boff   = 13'(($urandom % 512) * 4) - 13'd1024;
    we     = 1'b1;
    res    = '0;
    taken  = 1'b0;
    target = slot_pc + 32'd4;
    if (kind < 6) begin
      alt  = alt && (f3 == 3'd0 || f3 == 3'd5);
      word = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
      res  = alu_ref(f3, alt, regs_model[rs1], regs_model[rs2]);
    end else if (kind < 12) begin
      alt = alt && (f3 == 3'd5);
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm12[11:5] = alt ? 7'h20 : 7'h00;  // Shift amount sits in imm[4:0]
      end
      word = {imm12, rs1, f3, rd, 7'b0010011};
      res  = alu_ref(f3, alt, regs_model[rs1], {{20{imm12[11]}}, imm12});
    end else if (kind == 12) begin
      word = {imm20, rd, 7'b0110111};
      res  = {imm20, 12'h000};
    end else if (kind == 13) begin
      word = {imm20, rd, 7'b0010111};
      res  = slot_pc + {imm20, 12'h000};
    end else if (kind == 14) begin
      word   = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      res    = slot_pc + 32'd4;
      taken  = 1'b1;
      target = slot_pc + {{11{joff[20]}}, joff};
    end else if (kind == 15) begin
      for (int i = 0; i < 8 && regs_model[rs1][1:0] != 2'b00; i++) begin
        rs1 = pick_reg();
      end
      if (regs_model[rs1][1:0] != 2'b00) begin
        rs1 = 5'd0;
      end
      word   = {imm12, rs1, 3'b000, rd, 7'b1100111};
      res    = slot_pc + 32'd4;
      taken  = 1'b1;
      target = (regs_model[rs1] + {{20{imm12[11]}}, imm12}) & 32'hffff_fffe;
    end else begin
      bsel  = $urandom % 6;
      f3    = (bsel < 2) ? 3'(bsel) : 3'(bsel + 2);
      word  = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
      we    = 1'b0;
      taken = branch_ref(f3, regs_model[rs1], regs_model[rs2]);
      if (taken) begin
        target = slot_pc + {{19{boff[12]}}, boff};
      end
    end
    if (on_path) begin
      expected.valid = 1'b1;
      expected.rd    = rd;
      expected.we    = we && (rd != 5'd0);
      expected.data  = res;
      if (expected.we) begin
        regs_model[rd] = res;
      end
      exp_commit_q.push_back(expected);
      exp_redirect_q.push_back({taken, target});
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic check_commit();
    commit_t     expected;
    logic [32:0] redir;
    if (exp_commit_q.size() == 0) begin
      errors++;
      $display("commit seen with no instruction left in the reference model");
    end else begin
      expected = exp_commit_q.pop_front();
      redir    = exp_redirect_q.pop_front();
      checked++;
      check_value("commit.we", 32'(expected.we), 32'(commit.we));
      if (expected.we) begin
        check_value("commit.rd", 32'(expected.rd), 32'(commit.rd));
        check_value("commit.data", expected.data, commit.data);
      end
      check_value("redirect_valid", 32'(redir[32]), 32'(redirect_valid));
      if (redir[32]) begin
        check_value("redirect_pc", redir[31:0], redirect_pc);
      end
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      if (commit.valid) begin
        check_commit();
      end else if (redirect_valid) begin
        errors++;
        $display("redirect_valid was raised without a commit");
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout, the expected commits did not complete");
    $display("CHECKS FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Program stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [31:0] word;
    logic        taken;
    logic [31:0] target;
    logic [31:0] fetch_pc;
    logic [31:0] wp_pc;
    int          skip;
    int          slots;
    seed        = $urandom(67);
    errors      = 0;
    checked     = 0;
    reset       = 1'b1;
    block       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    for (int i = 0; i < 32; i++) begin
      regs_model[i] = '0;
    end
    fetch_pc = 32'h0000_1000;
    wp_pc    = '0;
    skip     = 0;
    slots    = 0;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
    while (slots < num_slots) begin
      @(posedge clock);
      #1;
      if ($urandom % 10 == 0) begin
        block       = 1'b1;
        instr_valid = 1'($urandom);
        instr       = $urandom;  // Whatever sits here is ignored during a stall
      end else begin
        block       = 1'b0;
        instr_valid = 1'b1;
        if (skip > 0) begin
          gen_slot(1'b0, wp_pc, word, taken, target);  // Wrong path, squashed by the DUT
          pc    = wp_pc;
          wp_pc = wp_pc + 32'd4;
          skip--;
        end else begin
          gen_slot(1'b1, fetch_pc, word, taken, target);
          pc = fetch_pc;
          if (taken) begin
            skip     = 2;
            wp_pc    = fetch_pc + 32'd4;
            fetch_pc = target;
          end else begin
            fetch_pc = fetch_pc + 32'd4;
          end
        end
        instr = word;
        slots++;
      end
    end
    @(posedge clock);
    #1;
    block       = 1'b0;
    instr_valid = 1'b0;
    while (exp_commit_q.size() != 0) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
    $display("errors %0d, commits checked %0d", errors, checked);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* rv_exec_core.f */
design/rv_isa_pkg.sv
design/exec_ctrl_pkg.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_execute.sv
design/rv_commit.sv
design/rv_exec_core.sv
verification/rv_exec_core_checker.sv
verification/rv_exec_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_exec_core.f \
  --top-module rv_exec_core_tb -o rv_exec_core_sim

./obj_dir/rv_exec_core_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
